/* hw/rv_decode_pkg.sv */
// ISA widths, opcode constants and decode enumerations for the decode stage
package rv_decode_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  // wider than the four bytes a store can touch
  localparam int STRB_W     = 8;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_U,
    IMM_S,
    IMM_J,
    IMM_B,
    IMM_R,
    IMM_NONE
  } imm_type_e;

  typedef enum logic [4:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    MUL,
    MULHU,
    DIV,
    DIVU,
    REM,
    REMU,
    PASS_IMM
  } alu_op_e;

  // PC_REG clears bit 0 of rs1 + imm
  typedef enum logic [1:0] {
    PC_SEQ,
    PC_REL,
    PC_REG
  } pc_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_LINK
  } wb_sel_e;

  typedef enum logic {RS1, PC} src1_sel_e;
  typedef enum logic {RS2, IMM} src2_sel_e;

endpackage

/* hw/imm_gen.sv */
// opcode class detection and sign-extended immediate assembly
`timescale 1ns/1ps
module imm_gen (
  input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
  output rv_decode_pkg::imm_type_e       imm_type_o,
  output logic [rv_decode_pkg::XLEN-1:0] imm_o
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;

  assign opcode = instr_i[6:0];

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC:            imm_type_o = IMM_U;
      OPC_JAL:                       imm_type_o = IMM_J;
      OPC_JALR, OPC_LOAD, OPC_OP_IMM: imm_type_o = IMM_I;
      OPC_STORE:                     imm_type_o = IMM_S;
      OPC_BRANCH:                    imm_type_o = IMM_B;
      OPC_OP:                        imm_type_o = IMM_R;
      default:                       imm_type_o = IMM_NONE;
    endcase
  end

  // bit 31 is the sign for every format
  always_comb begin
    case (imm_type_o)
      IMM_I:   imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
      IMM_S:   imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      IMM_B:   imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
      IMM_U:   imm_o = {instr_i[31:12], 12'b0};
      IMM_J:   imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      default: imm_o = '0;
    endcase
  end

endmodule

/* hw/ctrl_decoder.sv */
// ALU operation, operand sources, memory masks, write-back select and enables
`timescale 1ns/1ps
module ctrl_decoder (
  input  logic [rv_decode_pkg::XLEN-1:0]   instr_i,
  input  rv_decode_pkg::imm_type_e         imm_type_i,
  output rv_decode_pkg::alu_op_e           alu_op_o,
  output rv_decode_pkg::src1_sel_e         src1_sel_o,
  output rv_decode_pkg::src2_sel_e         src2_sel_o,
  output rv_decode_pkg::pc_sel_e           pc_sel_o,
  output logic                             is_branch_o,
  output rv_decode_pkg::wb_sel_e           wb_sel_o,
  output logic                             mem_ren_o,
  output logic                             mem_wen_o,
  output logic [rv_decode_pkg::STRB_W-1:0] mem_wmask_o,
  output logic [rv_decode_pkg::XLEN-1:0]   mem_rmask_o,
  output logic                             mem_signed_o,
  output logic                             reg_we_o
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e    op_alu;
  alu_op_e    op_imm_alu;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // register-register ops with the M extension under funct7 = 1
  always_comb begin
    case ({funct7, funct3})
      10'b0000000_000: op_alu = ADD;
      10'b0100000_000: op_alu = SUB;
      10'b0000000_001: op_alu = SLL;
      10'b0000000_010: op_alu = SLT;
      10'b0000000_011: op_alu = SLTU;
      10'b0000000_100: op_alu = XOR;
      10'b0000000_101: op_alu = SRL;
      10'b0100000_101: op_alu = SRA;
      10'b0000000_110: op_alu = OR;
      10'b0000000_111: op_alu = AND;
      10'b0000001_000: op_alu = MUL;
      10'b0000001_011: op_alu = MULHU;
      10'b0000001_100: op_alu = DIV;
      10'b0000001_101: op_alu = DIVU;
      10'b0000001_110: op_alu = REM;
      10'b0000001_111: op_alu = REMU;
      default:         op_alu = ADD;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b001:  op_imm_alu = SLL;
      3'b010:  op_imm_alu = SLT;
      3'b011:  op_imm_alu = SLTU;
      3'b100:  op_imm_alu = XOR;
      3'b101:  op_imm_alu = funct7[5] ? SRA : SRL;
      3'b110:  op_imm_alu = OR;
      3'b111:  op_imm_alu = AND;
      default: op_imm_alu = ADD;
    endcase
  end

  always_comb begin
    alu_op_o   = ADD;
    src1_sel_o = RS1;
    src2_sel_o = RS2;
    pc_sel_o   = PC_SEQ;
    wb_sel_o   = WB_ALU;
    mem_ren_o  = 1'b0;
    mem_wen_o  = 1'b0;
    case (opcode)
      OPC_OP: alu_op_o = op_alu;
      OPC_OP_IMM: begin
        alu_op_o   = op_imm_alu;
        src2_sel_o = IMM;
      end
      OPC_LUI: begin
        alu_op_o   = PASS_IMM;
        src2_sel_o = IMM;
      end
      OPC_AUIPC: begin
        src1_sel_o = PC;
        src2_sel_o = IMM;
      end
      OPC_JAL: begin
        src1_sel_o = PC;
        pc_sel_o   = PC_REL;
        wb_sel_o   = WB_LINK;
      end
      OPC_JALR: begin
        pc_sel_o = PC_REG;
        wb_sel_o = WB_LINK;
      end
      OPC_BRANCH: pc_sel_o = PC_REL;
      OPC_LOAD: begin
        src2_sel_o = IMM;
        wb_sel_o   = WB_MEM;
        mem_ren_o  = 1'b1;
      end
      OPC_STORE: begin
        src2_sel_o = IMM;
        mem_wen_o  = 1'b1;
      end
      default: alu_op_o = ADD;
    endcase
  end

  assign is_branch_o = (opcode == OPC_BRANCH);
  // stores, branches and unknown opcodes leave the register file alone
  assign reg_we_o    = imm_type_i inside {IMM_I, IMM_U, IMM_J, IMM_R};

  always_comb begin
    case (funct3)
      3'b000:  mem_wmask_o = 8'h01;
      3'b001:  mem_wmask_o = 8'h03;
      default: mem_wmask_o = 8'h0f;
    endcase
    case (funct3)
      3'b000, 3'b100: mem_rmask_o = 32'h0000_00ff;
      3'b001, 3'b101: mem_rmask_o = 32'h0000_ffff;
      default:        mem_rmask_o = '1;
    endcase
  end

  // lb and lh sign-extend
  assign mem_signed_o = mem_ren_o && (funct3[2:1] == 2'b00);

  // immediate class from imm_gen must agree with the store decode
  always_comb begin
    assert (!(mem_wen_o && reg_we_o))
      else $error("store decoded with a register write");
  end

endmodule

/* hw/operand_bypass.sv */
// forwarding from execute and write-back, then ALU operand selection
`timescale 1ns/1ps
module operand_bypass (
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       rs2_data_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       pc_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       imm_i,
  input  rv_decode_pkg::src1_sel_e             src1_sel_i,
  input  rv_decode_pkg::src2_sel_e             src2_sel_i,
  input  logic                                 exu_busy_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] exu_rd_i,
  input  logic                                 exu_we_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       exu_wd_i,
  input  logic                                 wbu_busy_i,
  input  logic                                 wbu_reg_we_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] wbu_rd_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       wbu_wd_i,
  output logic [rv_decode_pkg::XLEN-1:0]       rs1_val_o,
  output logic [rv_decode_pkg::XLEN-1:0]       rs2_val_o,
  output logic [rv_decode_pkg::XLEN-1:0]       src1_o,
  output logic [rv_decode_pkg::XLEN-1:0]       src2_o
);
  import rv_decode_pkg::*;

  // youngest producer wins, x0 is never forwarded
  function automatic logic [XLEN-1:0] forward(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0]       rf_data
  );
    logic nonzero;
    nonzero = (addr != '0);
    if (nonzero && exu_busy_i && exu_we_i && (exu_rd_i == addr)) begin
      return exu_wd_i;
    end else if (nonzero && wbu_busy_i && wbu_reg_we_i && (wbu_rd_i == addr)) begin
      return wbu_wd_i;
    end
    return rf_data;
  endfunction

  assign rs1_val_o = forward(rs1_addr_i, rs1_data_i);
  assign rs2_val_o = forward(rs2_addr_i, rs2_data_i);

  assign src1_o = (src1_sel_i == PC) ? pc_i : rs1_val_o;
  assign src2_o = (src2_sel_i == IMM) ? imm_i : rs2_val_o;

endmodule

/* hw/next_pc_unit.sv */
// branch condition evaluation and next-PC selection
`timescale 1ns/1ps
module next_pc_unit (
  input  logic [rv_decode_pkg::XLEN-1:0] pc_i,
  input  logic [rv_decode_pkg::XLEN-1:0] imm_i,
  input  logic [rv_decode_pkg::XLEN-1:0] rs1_val_i,
  input  logic [rv_decode_pkg::XLEN-1:0] rs2_val_i,
  input  rv_decode_pkg::pc_sel_e         pc_sel_i,
  input  logic                           is_branch_i,
  input  logic [2:0]                     funct3_i,
  output logic [rv_decode_pkg::XLEN-1:0] next_pc_o
);
  import rv_decode_pkg::*;

  logic            taken;
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] reg_sum;

  assign seq_pc  = pc_i + 32'd4;
  assign reg_sum = rs1_val_i + imm_i;

  always_comb begin
    case (funct3_i)
      3'b000:  taken = (rs1_val_i == rs2_val_i);
      3'b001:  taken = (rs1_val_i != rs2_val_i);
      3'b100:  taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
      3'b101:  taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
      3'b110:  taken = (rs1_val_i < rs2_val_i);
      3'b111:  taken = (rs1_val_i >= rs2_val_i);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_branch_i && !taken) begin
      next_pc_o = seq_pc;
    end else begin
      case (pc_sel_i)
        PC_REL:  next_pc_o = pc_i + imm_i;
        // jalr target is halfword aligned
        PC_REG:  next_pc_o = {reg_sum[XLEN-1:1], 1'b0};
        default: next_pc_o = seq_pc;
      endcase
    end
  end

endmodule

/* hw/decode_stage.sv */
// decode stage top with the accept/issue FSM, load hazard stall and issue registers
`timescale 1ns/1ps
module decode_stage (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [rv_decode_pkg::XLEN-1:0]       instr_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       pc_i,
  input  logic                                 receive_valid_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       rs2_data_i,
  input  logic                                 exu_busy_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       exu_wd_i,
  input  logic                                 wbu_busy_i,
  input  logic                                 wbu_reg_we_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] wbu_rd_i,
  input  logic [rv_decode_pkg::XLEN-1:0]       wbu_wd_i,
  input  logic                                 lsu_busy_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] lsu_rd_i,
  input  logic                                 issue_ready_i,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  output logic                                 issue_valid_o,
  output logic                                 pc_write_en_o,
  output logic [rv_decode_pkg::XLEN-1:0]       pc_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv_decode_pkg::XLEN-1:0]       imm_o,
  output rv_decode_pkg::alu_op_e               alu_op_o,
  output logic [rv_decode_pkg::XLEN-1:0]       src1_o,
  output logic [rv_decode_pkg::XLEN-1:0]       src2_o,
  output rv_decode_pkg::wb_sel_e               wb_sel_o,
  output logic                                 mem_ren_o,
  output logic                                 mem_wen_o,
  output logic [rv_decode_pkg::STRB_W-1:0]     mem_wmask_o,
  output logic [rv_decode_pkg::XLEN-1:0]       mem_rmask_o,
  output logic                                 mem_signed_o,
  output logic                                 reg_we_o,
  output logic [rv_decode_pkg::XLEN-1:0]       next_pc_o
);
  import rv_decode_pkg::*;

  typedef enum logic {IDLE, DECODE} state_e;

  state_e            state_q;
  state_e            state_d;
  imm_type_e         imm_type;
  logic [XLEN-1:0]   imm;
  alu_op_e           alu_op;
  src1_sel_e         src1_sel;
  src2_sel_e         src2_sel;
  pc_sel_e           pc_sel;
  logic              is_branch;
  wb_sel_e           wb_sel;
  logic              mem_ren;
  logic              mem_wen;
  logic [STRB_W-1:0] mem_wmask;
  logic [XLEN-1:0]   mem_rmask;
  logic              mem_signed;
  logic              reg_we;
  logic [XLEN-1:0]   rs1_val;
  logic [XLEN-1:0]   rs2_val;
  logic [XLEN-1:0]   src1;
  logic [XLEN-1:0]   src2;
  logic [XLEN-1:0]   next_pc;
  logic              load_hazard;
  logic              issue_load;

  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  // load result not back yet for a source register
  assign load_hazard = lsu_busy_i && ((lsu_rd_i == rs1_addr_o) || (lsu_rd_i == rs2_addr_o));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (receive_valid_i) state_d = DECODE;
      DECODE:  if (issue_valid_o && issue_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign issue_load    = (state_d == DECODE) && !issue_valid_o && !load_hazard;
  assign pc_write_en_o = issue_valid_o && issue_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= IDLE;
      issue_valid_o <= 1'b0;
      mem_ren_o     <= 1'b0;
      mem_wen_o     <= 1'b0;
      reg_we_o      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (issue_load) begin
        issue_valid_o <= 1'b1;
        mem_ren_o     <= mem_ren;
        mem_wen_o     <= mem_wen;
        reg_we_o      <= reg_we;
      end else if (issue_valid_o && issue_ready_i) begin
        issue_valid_o <= 1'b0;
      end
    end
  end

  // payload holds under back-pressure
  always_ff @(posedge clk) begin
    if (issue_load) begin
      pc_o         <= pc_i;
      rd_o         <= instr_i[11:7];
      imm_o        <= imm;
      alu_op_o     <= alu_op;
      src1_o       <= src1;
      src2_o       <= src2;
      wb_sel_o     <= wb_sel;
      mem_wmask_o  <= mem_wmask;
      mem_rmask_o  <= mem_rmask;
      mem_signed_o <= mem_signed;
      next_pc_o    <= next_pc;
    end
  end

  imm_gen u_imm_gen (
    .instr_i   (instr_i),
    .imm_type_o(imm_type),
    .imm_o     (imm)
  );

  ctrl_decoder u_ctrl_decoder (
    .instr_i     (instr_i),
    .imm_type_i  (imm_type),
    .alu_op_o    (alu_op),
    .src1_sel_o  (src1_sel),
    .src2_sel_o  (src2_sel),
    .pc_sel_o    (pc_sel),
    .is_branch_o (is_branch),
    .wb_sel_o    (wb_sel),
    .mem_ren_o   (mem_ren),
    .mem_wen_o   (mem_wen),
    .mem_wmask_o (mem_wmask),
    .mem_rmask_o (mem_rmask),
    .mem_signed_o(mem_signed),
    .reg_we_o    (reg_we)
  );

  // issued rd and reg_we name the instruction now in execute
  operand_bypass u_operand_bypass (
    .rs1_addr_i  (rs1_addr_o),
    .rs2_addr_i  (rs2_addr_o),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .pc_i        (pc_i),
    .imm_i       (imm),
    .src1_sel_i  (src1_sel),
    .src2_sel_i  (src2_sel),
    .exu_busy_i  (exu_busy_i),
    .exu_rd_i    (rd_o),
    .exu_we_i    (reg_we_o),
    .exu_wd_i    (exu_wd_i),
    .wbu_busy_i  (wbu_busy_i),
    .wbu_reg_we_i(wbu_reg_we_i),
    .wbu_rd_i    (wbu_rd_i),
    .wbu_wd_i    (wbu_wd_i),
    .rs1_val_o   (rs1_val),
    .rs2_val_o   (rs2_val),
    .src1_o      (src1),
    .src2_o      (src2)
  );

  next_pc_unit u_next_pc_unit (
    .pc_i       (pc_i),
    .imm_i      (imm),
    .rs1_val_i  (rs1_val),
    .rs2_val_i  (rs2_val),
    .pc_sel_i   (pc_sel),
    .is_branch_i(is_branch),
    .funct3_i   (instr_i[14:12]),
    .next_pc_o  (next_pc)
  );

  // issue register only valid while the FSM sits in DECODE
  a_valid_in_decode : assert property (@(posedge clk) disable iff (rst)
    issue_valid_o |-> (state_q == DECODE))
    else $error("issue_valid_o high outside DECODE");

endmodule

/* include/decode_checks.svh */
// compare tasks for issue fields of the decode stage
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

// first mismatch ends the run
task automatic report_fail(input string name, input string exp_s, input string act_s);
  $display("FAIL at %0t: %s expected %s actual %s", $time, name, exp_s, act_s);
  $display("Simulation failed");
  $fatal(1, "mismatch on %s", name);
endtask

task automatic check_word(
  input string                          name,
  input logic [rv_decode_pkg::XLEN-1:0] exp_v,
  input logic [rv_decode_pkg::XLEN-1:0] act_v
);
  if (act_v !== exp_v) begin
    report_fail(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
  end
endtask

task automatic check_reg(
  input string                                name,
  input logic [rv_decode_pkg::REG_ADDR_W-1:0] exp_v,
  input logic [rv_decode_pkg::REG_ADDR_W-1:0] act_v
);
  if (act_v !== exp_v) begin
    report_fail(name, $sformatf("x%0d", exp_v), $sformatf("x%0d", act_v));
  end
endtask

task automatic check_alu_op(
  input string                  name,
  input rv_decode_pkg::alu_op_e exp_v,
  input rv_decode_pkg::alu_op_e act_v
);
  if (act_v !== exp_v) begin
    report_fail(name, $sformatf("%s(%0d)", exp_v.name(), exp_v),
                $sformatf("%s(%0d)", act_v.name(), act_v));
  end
endtask

task automatic check_wb_sel(
  input string                  name,
  input rv_decode_pkg::wb_sel_e exp_v,
  input rv_decode_pkg::wb_sel_e act_v
);
  if (act_v !== exp_v) begin
    report_fail(name, $sformatf("%s(%0d)", exp_v.name(), exp_v),
                $sformatf("%s(%0d)", act_v.name(), act_v));
  end
endtask

task automatic check_bit(input string name, input logic exp_v, input logic act_v);
  if (act_v !== exp_v) begin
    report_fail(name, $sformatf("%b", exp_v), $sformatf("%b", act_v));
  end
endtask

`endif

/* sim/decode_stage_tb.sv */
// decode stage testbench with vector replay, branches, forwarding, stall and back-pressure
`timescale 1ns/1ps
module decode_stage_tb;
  import rv_decode_pkg::*;

  localparam int N_ROWS    = 27;
  localparam int ROW_WORDS = 13;
  localparam int MAX_WAIT  = 20;

  logic                  clk;
  logic                  rst;
  logic [XLEN-1:0]       instr_i;
  logic [XLEN-1:0]       pc_i;
  logic                  receive_valid_i;
  logic [XLEN-1:0]       rs1_data_i;
  logic [XLEN-1:0]       rs2_data_i;
  logic                  exu_busy_i;
  logic [XLEN-1:0]       exu_wd_i;
  logic                  wbu_busy_i;
  logic                  wbu_reg_we_i;
  logic [REG_ADDR_W-1:0] wbu_rd_i;
  logic [XLEN-1:0]       wbu_wd_i;
  logic                  lsu_busy_i;
  logic [REG_ADDR_W-1:0] lsu_rd_i;
  logic                  issue_ready_i;
  logic [REG_ADDR_W-1:0] rs1_addr_o;
  logic [REG_ADDR_W-1:0] rs2_addr_o;
  logic                  issue_valid_o;
  logic                  pc_write_en_o;
  logic [XLEN-1:0]       pc_o;
  logic [REG_ADDR_W-1:0] rd_o;
  logic [XLEN-1:0]       imm_o;
  alu_op_e               alu_op_o;
  logic [XLEN-1:0]       src1_o;
  logic [XLEN-1:0]       src2_o;
  wb_sel_e               wb_sel_o;
  logic                  mem_ren_o;
  logic                  mem_wen_o;
  logic [STRB_W-1:0]     mem_wmask_o;
  logic [XLEN-1:0]       mem_rmask_o;
  logic                  mem_signed_o;
  logic                  reg_we_o;
  logic [XLEN-1:0]       next_pc_o;

  logic [31:0] vec_mem [0:N_ROWS*ROW_WORDS-1];
  integer      seed;
  logic [XLEN-1:0] fwd_val;
  logic [XLEN-1:0] rf_val;

  `include "decode_checks.svh"

  decode_stage uut (
    .clk(clk), .rst(rst), .instr_i(instr_i), .pc_i(pc_i),
    .receive_valid_i(receive_valid_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
    .exu_busy_i(exu_busy_i), .exu_wd_i(exu_wd_i), .wbu_busy_i(wbu_busy_i),
    .wbu_reg_we_i(wbu_reg_we_i), .wbu_rd_i(wbu_rd_i), .wbu_wd_i(wbu_wd_i),
    .lsu_busy_i(lsu_busy_i), .lsu_rd_i(lsu_rd_i), .issue_ready_i(issue_ready_i),
    .rs1_addr_o(rs1_addr_o), .rs2_addr_o(rs2_addr_o), .issue_valid_o(issue_valid_o),
    .pc_write_en_o(pc_write_en_o), .pc_o(pc_o), .rd_o(rd_o), .imm_o(imm_o),
    .alu_op_o(alu_op_o), .src1_o(src1_o), .src2_o(src2_o), .wb_sel_o(wb_sel_o),
    .mem_ren_o(mem_ren_o), .mem_wen_o(mem_wen_o), .mem_wmask_o(mem_wmask_o),
    .mem_rmask_o(mem_rmask_o), .mem_signed_o(mem_signed_o), .reg_we_o(reg_we_o),
    .next_pc_o(next_pc_o)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "%s", msg);
  endtask

  // drive on the falling edge and hold until issue
  task automatic present_instr(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc);
    @(negedge clk);
    instr_i         = instr;
    pc_i            = pc;
    receive_valid_i = 1'b1;
    issue_ready_i   = 1'b0;
  endtask

  task automatic wait_for_issue();
    int n;
    n = 0;
    while (issue_valid_o !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > MAX_WAIT) begin
        abort_run("issue_valid_o never rose for the presented instruction");
      end
    end
  endtask

  // pc_write_en_o only while valid and ready
  task automatic accept_issue();
    check_bit("pc_write_en_o", 1'b0, pc_write_en_o);
    issue_ready_i   = 1'b1;
    receive_valid_i = 1'b0;
    #2;
    check_bit("pc_write_en_o", 1'b1, pc_write_en_o);
    @(negedge clk);
    check_bit("issue_valid_o", 1'b0, issue_valid_o);
    check_bit("pc_write_en_o", 1'b0, pc_write_en_o);
    issue_ready_i = 1'b0;
  endtask

  task automatic check_row(input int r);
    int b;
    b = r * ROW_WORDS;
    rs1_data_i = vec_mem[b+2];
    rs2_data_i = vec_mem[b+3];
    present_instr(vec_mem[b], vec_mem[b+1]);
    wait_for_issue();
    check_word("pc_o", vec_mem[b+1], pc_o);
    check_word("imm_o", vec_mem[b+4], imm_o);
    check_word("src1_o", vec_mem[b+5], src1_o);
    check_word("src2_o", vec_mem[b+6], src2_o);
    check_word("next_pc_o", vec_mem[b+7], next_pc_o);
    check_word("mem_rmask_o", vec_mem[b+8], mem_rmask_o);
    check_alu_op("alu_op_o", alu_op_e'(vec_mem[b+9][4:0]), alu_op_o);
    check_wb_sel("wb_sel_o", wb_sel_e'(vec_mem[b+10][1:0]), wb_sel_o);
    check_word("mem_wmask_o", {24'h0, vec_mem[b+11][7:0]}, {24'h0, mem_wmask_o});
    check_bit("mem_ren_o", vec_mem[b+12][3], mem_ren_o);
    check_bit("mem_wen_o", vec_mem[b+12][2], mem_wen_o);
    check_bit("mem_signed_o", vec_mem[b+12][1], mem_signed_o);
    check_bit("reg_we_o", vec_mem[b+12][0], reg_we_o);
    accept_issue();
  endtask

  // branch at pc 0x100 with the given x1 and x2 values
  task automatic check_branch(
    input logic [XLEN-1:0] instr,
    input logic [XLEN-1:0] rs1_val,
    input logic [XLEN-1:0] rs2_val,
    input logic [XLEN-1:0] exp_pc
  );
    rs1_data_i = rs1_val;
    rs2_data_i = rs2_val;
    present_instr(instr, 32'h0000_0100);
    wait_for_issue();
    check_word("next_pc_o", exp_pc, next_pc_o);
    accept_issue();
  endtask

  // reader of rs1 under the current forwarding state
  task automatic check_forward(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] exp_src1);
    present_instr(instr, 32'h0000_0200);
    rs1_data_i = rf_val;
    wait_for_issue();
    check_word("src1_o", exp_src1, src1_o);
    accept_issue();
  endtask

  initial begin
    #((N_ROWS * 20 + 500) * 20);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    seed            = 32'hf858_c4eb;
    clk             = 1'b0;
    rst             = 1'b1;
    instr_i         = '0;
    pc_i            = '0;
    receive_valid_i = 1'b0;
    rs1_data_i      = '0;
    rs2_data_i      = '0;
    exu_busy_i      = 1'b0;
    exu_wd_i        = '0;
    wbu_busy_i      = 1'b0;
    wbu_reg_we_i    = 1'b0;
    wbu_rd_i        = '0;
    wbu_wd_i        = '0;
    lsu_busy_i      = 1'b0;
    lsu_rd_i        = '0;
    issue_ready_i   = 1'b0;
    // the last flags word of a complete file replaces this marker
    vec_mem[N_ROWS*ROW_WORDS-1] = 32'hffff_ffff;
    $readmemh("sim/decode_vectors.hex", vec_mem);
    if (vec_mem[N_ROWS*ROW_WORDS-1] === 32'hffff_ffff) begin
      abort_run("vector file missing or too short");
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("issue_valid_o", 1'b0, issue_valid_o);
    check_bit("pc_write_en_o", 1'b0, pc_write_en_o);
    check_bit("reg_we_o", 1'b0, reg_we_o);
    check_bit("mem_ren_o", 1'b0, mem_ren_o);
    check_bit("mem_wen_o", 1'b0, mem_wen_o);

    for (int r = 0; r < N_ROWS; r++) begin
      check_row(r);
    end

    // branch outcomes not covered by the vector rows
    check_branch(32'h0020_9863, 32'h0000_0005, 32'h0000_0005, 32'h0000_0104);
    check_branch(32'h0020_c863, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0104);
    check_branch(32'h0020_d863, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0110);
    check_branch(32'h0020_e863, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0110);
    check_branch(32'h0020_f863, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0104);

    // writer of x3 followed by readers of x3
    rs2_data_i = 32'h0000_0008;
    present_instr(32'h0020_81b3, 32'h0000_01fc);
    wait_for_issue();
    check_reg("rd_o", 5'd3, rd_o);
    accept_issue();
    rf_val     = $random(seed);
    fwd_val    = $random(seed);
    exu_busy_i = 1'b1;
    exu_wd_i   = fwd_val;
    wbu_busy_i   = 1'b1;
    wbu_reg_we_i = 1'b1;
    wbu_rd_i     = 5'd3;
    wbu_wd_i     = ~fwd_val;
    check_forward(32'h0021_81b3, fwd_val);
    exu_busy_i = 1'b0;
    wbu_wd_i   = $random(seed);
    check_forward(32'h0021_81b3, wbu_wd_i);
    wbu_rd_i = 5'd0;
    check_forward(32'h0020_01b3, rf_val);
    // x0 destination in execute
    check_forward(32'h0020_8033, rf_val);
    exu_busy_i = 1'b1;
    check_forward(32'h0020_01b3, rf_val);
    exu_busy_i   = 1'b0;
    wbu_busy_i   = 1'b0;
    wbu_reg_we_i = 1'b0;

    // load hazard on x1
    lsu_busy_i = 1'b1;
    lsu_rd_i   = 5'd1;
    present_instr(32'h0020_81b3, 32'h0000_0300);
    rs1_data_i = 32'h0000_0011;
    repeat (4) begin
      @(negedge clk);
      check_bit("issue_valid_o", 1'b0, issue_valid_o);
      check_reg("rs1_addr_o", 5'd1, rs1_addr_o);
      check_reg("rs2_addr_o", 5'd2, rs2_addr_o);
    end
    lsu_busy_i = 1'b0;
    wait_for_issue();
    check_word("src1_o", 32'h0000_0011, src1_o);

    // back-pressure holds the issued fields
    repeat (3) begin
      rs1_data_i = $random(seed);
      @(negedge clk);
      check_bit("issue_valid_o", 1'b1, issue_valid_o);
      check_bit("pc_write_en_o", 1'b0, pc_write_en_o);
      check_word("src1_o", 32'h0000_0011, src1_o);
      check_word("pc_o", 32'h0000_0300, pc_o);
    end
    accept_issue();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* sim/decode_vectors.hex */
// instr pc rs1_data rs2_data | imm src1 src2 next_pc rmask alu_op wb_sel wmask
// flags = {mem_ren, mem_wen, mem_signed, reg_we}
002081b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 000000ff 00 0 01 1
402081b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 000000ff 01 0 01 1
022081b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 000000ff 0a 0 01 1
0220b1b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 ffffffff 0b 0 0f 1
0220c1b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 000000ff 0c 0 0f 1
0220d1b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 0000ffff 0d 0 0f 1
0220e1b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 ffffffff 0e 0 0f 1
0220f1b3 00000100 00000020 00000008 00000000 00000020 00000008 00000104 ffffffff 0f 0 0f 1
ffc08293 00000100 00000020 00000008 fffffffc 00000020 fffffffc 00000104 000000ff 00 0 01 1
4030d293 00000100 00000020 00000008 00000403 00000020 00000403 00000104 0000ffff 07 0 0f 1
12345337 00000100 00000020 00000008 12345000 00000020 12345000 00000104 0000ffff 10 0 0f 1
00001397 00000100 00000020 00000008 00001000 00000100 00001000 00000104 0000ffff 00 0 03 1
0080a403 00000100 00000020 00000008 00000008 00000020 00000008 00000104 ffffffff 00 1 0f 9
fff08403 00000100 00000020 00000008 ffffffff 00000020 ffffffff 00000104 000000ff 00 1 01 b
0020d403 00000100 00000020 00000008 00000002 00000020 00000002 00000104 0000ffff 00 1 0f 9
0020a623 00000100 00000020 00000008 0000000c 00000020 0000000c 00000104 ffffffff 00 0 0f 4
fe208fa3 00000100 00000020 00000008 ffffffff 00000020 ffffffff 00000104 000000ff 00 0 01 4
00209223 00000100 00000020 00000008 00000004 00000020 00000004 00000104 0000ffff 00 0 03 4
00208863 00000100 00000005 00000005 00000010 00000005 00000005 00000110 000000ff 00 0 01 0
00208863 00000100 00000005 00000006 00000010 00000005 00000006 00000104 000000ff 00 0 01 0
00209863 00000100 00000005 00000006 00000010 00000005 00000006 00000110 0000ffff 00 0 03 0
0020c863 00000100 ffffffff 00000001 00000010 ffffffff 00000001 00000110 000000ff 00 0 0f 0
0020d863 00000100 ffffffff 00000001 00000010 ffffffff 00000001 00000104 0000ffff 00 0 0f 0
0020e863 00000100 ffffffff 00000001 00000010 ffffffff 00000001 00000104 ffffffff 00 0 0f 0
0020f863 00000100 ffffffff 00000001 00000010 ffffffff 00000001 00000110 ffffffff 00 0 0f 0
020000ef 00000100 00000020 00000008 00000020 00000100 00000008 00000120 000000ff 00 2 01 1
006080e7 00000100 00000201 00000008 00000006 00000201 00000008 00000206 000000ff 00 2 01 1

/* verilog.f */
+incdir+include
hw/rv_decode_pkg.sv
hw/imm_gen.sv
hw/ctrl_decoder.sv
hw/operand_bypass.sv
hw/next_pc_unit.sv
hw/decode_stage.sv
sim/decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f verilog.f --top-module decode_stage_tb -o sim_decode
status=$?
if [ $status -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_decode 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation completed successfully$"; then
  exit 0
fi
echo "pass message not found"
exit 1
